/* sources.f */
logic/fir_dsp_pkg.sv
logic/fir_regs_pkg.sv
logic/fir_sample_bus_if.sv
logic/fir_coef_regs.sv
logic/fir_sample_feed.sv
logic/fir_tap.sv
logic/fir_round_clip.sv
logic/fir_block.sv
verif/fir_block_tb.sv

/* Makefile */
# Verilator build and run for the FIR block testbench

VERILATOR ?= verilator
TOP       ?= fir_block_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard logic/*.sv verif/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* verif/fir_block_tb.sv */
/*
 * Self-checking testbench for the streaming complex FIR block,
 * table-driven with a golden convolution model
 */
`timescale 1ns/100ps

module fir_block_tb import fir_dsp_pkg::*, fir_regs_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int NUM_ROWS = 8;

  // Worst case covers the heaviest stall rate in the table
  localparam int CYCLES_PER_SAMPLE = 24;
  localparam int ROW_OVERHEAD = 64;

  localparam logic [1:0] PAT_IMPULSE = 2'd0;
  localparam logic [1:0] PAT_RANDOM = 2'd1;
  localparam logic [1:0] PAT_FULL = 2'd2;

  typedef struct packed {
    coef_bank_t  coefs;
    logic        complete;
    logic [1:0]  pattern;
    int unsigned len;
    int unsigned stall_pct;
  } row_t;

  logic        ce_clk;
  logic        i_arst_n;
  logic [31:0] i_in_tdata;
  logic        i_in_tlast;
  logic        i_in_tvalid;
  logic        o_in_tready;
  logic [31:0] o_out_tdata;
  logic        o_out_tlast;
  logic        o_out_tvalid;
  logic        i_out_tready;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic [7:0]  i_rb_addr;
  logic [63:0] o_rb_data;

  row_t        rows [NUM_ROWS];
  int          seed = 80718;
  int unsigned cur_stall = 0;
  int unsigned total_samples = 0;
  int          in_count = 0;
  int          out_count = 0;
  int          clip_hits = 0;
  int          ready_low_hits = 0;
  logic        out_held = 1'b0;
  logic [31:0] held_data;

  // Golden model state with the newest sample at index 0
  coef_bank_t                 model_coefs;
  logic signed [SAMPLE_W-1:0] hist_i [NUM_TAPS];
  logic signed [SAMPLE_W-1:0] hist_q [NUM_TAPS];
  coef_bank_t                 hist_bank [NUM_TAPS];
  logic [32:0]                exp_q [$];

  fir_block UUT (
    .ce_clk       (ce_clk),
    .i_arst_n     (i_arst_n),
    .i_in_tdata   (i_in_tdata),
    .i_in_tlast   (i_in_tlast),
    .i_in_tvalid  (i_in_tvalid),
    .o_in_tready  (o_in_tready),
    .o_out_tdata  (o_out_tdata),
    .o_out_tlast  (o_out_tlast),
    .o_out_tvalid (o_out_tvalid),
    .i_out_tready (i_out_tready),
    .i_set_stb    (i_set_stb),
    .i_set_addr   (i_set_addr),
    .i_set_data   (i_set_data),
    .i_rb_addr    (i_rb_addr),
    .o_rb_data    (o_rb_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Reporting and golden model
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped at the first failing check");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got == exp) else report_failure($sformatf(
      "Error at time %0t: %s expected %h, got %h", $time, name, exp, got));
  endtask

  function automatic logic [15:0] saturate16(input longint v);
    if (v > 32767) begin
      return 16'h7FFF;
    end else if (v < -32768) begin
      return 16'h8000;
    end else begin
      return v[15:0];
    end
  endfunction

  // True for either end of the 16-bit range
  function automatic logic at_full_scale(input logic [15:0] v);
    return (v == 16'h7FFF) || (v == 16'h8000);
  endfunction

  // Each stored sample keeps the coefficient set active when it arrived
  task automatic model_accept(input logic [31:0] data, input logic last);
    longint     sum_i;
    longint     sum_q;
    longint     rnd_i;
    longint     rnd_q;
    logic [2:0] idx;
    sum_i = 0;
    sum_q = 0;
    for (int j = NUM_TAPS - 1; j > 0; j--) begin
      hist_i[3'(j)]    = hist_i[3'(j - 1)];
      hist_q[3'(j)]    = hist_q[3'(j - 1)];
      hist_bank[3'(j)] = hist_bank[3'(j - 1)];
    end
    hist_i[0]    = data[31:16];
    hist_q[0]    = data[15:0];
    hist_bank[0] = model_coefs;
    for (int j = 0; j < NUM_TAPS; j++) begin
      idx   = 3'(j);
      sum_i = sum_i + longint'(hist_i[idx]) * longint'(hist_bank[idx][idx]);
      sum_q = sum_q + longint'(hist_q[idx]) * longint'(hist_bank[idx][idx]);
    end
    // Add half an LSB at the Q1.15 point and drop 15 bits
    rnd_i = (sum_i + 64'sd16384) >>> 15;
    rnd_q = (sum_q + 64'sd16384) >>> 15;
    exp_q.push_back({last, saturate16(rnd_i), saturate16(rnd_q)});
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic coef_bank_t make_bank(input int h0, input int h1, input int h2,
                                           input int h3, input int h4, input int h5,
                                           input int h6, input int h7);
    coef_bank_t b;
    b[0] = coef_t'(h0);
    b[1] = coef_t'(h1);
    b[2] = coef_t'(h2);
    b[3] = coef_t'(h3);
    b[4] = coef_t'(h4);
    b[5] = coef_t'(h5);
    b[6] = coef_t'(h6);
    b[7] = coef_t'(h7);
    return b;
  endfunction

  function automatic row_t make_row(input coef_bank_t bank, input logic complete,
                                    input logic [1:0] pattern, input int unsigned len,
                                    input int unsigned stall_pct);
    return '{bank, complete, pattern, len, stall_pct};
  endfunction

  task automatic fill_table();
    coef_bank_t set_a;
    coef_bank_t set_b;
    coef_bank_t set_f;
    set_a = make_bank(1024, -2048, 4096, 8192, 16384, -8192, 30000, -32768);
    set_b = make_bank(3277, 6554, 9830, 13107, 13107, 9830, 6554, 3277);
    set_f = make_bank(5000, -12000, 20000, 32767, 32767, 20000, -12000, 5000);
    rows[0] = make_row(set_a, 1'b1, PAT_IMPULSE, 12, 0);
    rows[1] = make_row(set_b, 1'b1, PAT_RANDOM, 24, 0);
    // Reload without the last write leaves set B active
    rows[2] = make_row(make_bank(-1000, 2000, -3000, 4000, -5000, 6000, -7000, 8000),
                       1'b0, PAT_RANDOM, 16, 0);
    rows[3] = make_row(make_bank(32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767),
                       1'b1, PAT_FULL, 12, 0);
    rows[4] = make_row(make_bank(-32768, -32768, -32768, -32768, -32768, -32768, -32768,
                                 -32768), 1'b1, PAT_FULL, 12, 25);
    rows[5] = make_row(set_f, 1'b1, PAT_RANDOM, 40, 60);
    rows[6] = make_row(make_bank(100, 200, 300, 400, 500, 600, 700, 800),
                       1'b0, PAT_RANDOM, 32, 75);
    rows[7] = make_row(set_a, 1'b1, PAT_IMPULSE, 12, 40);
    for (int r = 0; r < NUM_ROWS; r++) begin
      total_samples += rows[3'(r)].len;
    end
  endtask

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    @(negedge ce_clk);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge ce_clk);
    i_set_stb  = 1'b0;
  endtask

  // h0 goes first so that it ends up at tap 0
  task automatic load_coefs(input coef_bank_t bank, input logic complete);
    coef_bank_t work;
    work = bank;
    for (int k = 0; k < NUM_TAPS - 1; k++) begin
      write_setting(SR_RELOAD, {16'h0, work[0]});
      work = work >> COEF_W;
    end
    if (complete) begin
      write_setting(SR_RELOAD_LAST, {16'h0, work[0]});
    end
    write_setting(SR_CONFIG, 32'h0);
    if (complete) begin
      model_coefs = bank;
    end
  endtask

  task automatic check_readback(input logic [7:0] addr, input logic [63:0] exp);
    @(negedge ce_clk);
    i_rb_addr = addr;
    @(posedge ce_clk);
    check_value("o_rb_data", o_rb_data, exp);
  endtask

  task automatic make_sample(input logic [1:0] pattern, input int unsigned n,
                             output logic [31:0] data);
    case (pattern)
      PAT_IMPULSE: data = (n == 0) ? 32'h7FFF_7FFF : 32'h0;
      PAT_FULL:    data = 32'h7FFF_8000;
      default:     data = $random(seed);
    endcase
  endtask

  task automatic run_row(input row_t row);
    logic [31:0] data;
    cur_stall = row.stall_pct;
    load_coefs(row.coefs, row.complete);
    for (int unsigned n = 0; n < row.len; n++) begin
      @(negedge ce_clk);
      make_sample(row.pattern, n, data);
      i_in_tvalid = 1'b1;
      i_in_tdata  = data;
      i_in_tlast  = (n == row.len - 1);
      // Transfer happens on the first edge with ready high
      do begin
        @(posedge ce_clk);
        if (!o_in_tready) begin
          ready_low_hits++;
        end
      end while (!o_in_tready);
      model_accept(data, i_in_tlast);
      in_count++;
    end
    @(negedge ce_clk);
    i_in_tvalid = 1'b0;
    i_in_tlast  = 1'b0;
    while (out_count != in_count) begin
      @(negedge ce_clk);
    end
    check_value("o_out_tvalid", 64'(o_out_tvalid), 64'd0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Processes
  //////////////////////////////////////////////////////////////////////

  initial begin : clock_gen
    ce_clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) ce_clk = ~ce_clk;
    end
  end

  initial begin : stall_gen
    int r;
    i_out_tready = 1'b1;
    forever begin
      // Draw on the rising edge and apply on the falling edge
      @(posedge ce_clk);
      r = $random(seed);
      @(negedge ce_clk);
      i_out_tready = ((r & 32'h7FFF_FFFF) % 100) >= cur_stall;
    end
  end

  // Held output data must not move until it transfers
  always @(posedge ce_clk) begin
    if (i_arst_n) begin
      if (out_held) begin
        check_value("o_out_tvalid", 64'(o_out_tvalid), 64'd1);
        check_value("o_out_tdata", 64'(o_out_tdata), 64'(held_data));
      end
      if (o_out_tvalid && i_out_tready) begin
        assert (exp_q.size() != 0) else report_failure(
          "An output transfer arrived with no input left to match it");
        check_value("o_out_tdata", 64'(o_out_tdata), 64'(exp_q[0][31:0]));
        check_value("o_out_tlast", 64'(o_out_tlast), 64'(exp_q[0][32]));
        if (at_full_scale(o_out_tdata[31:16]) || at_full_scale(o_out_tdata[15:0])) begin
          clip_hits++;
        end
        void'(exp_q.pop_front());
        out_count++;
      end
      out_held  = o_out_tvalid && !i_out_tready;
      held_data = o_out_tdata;
    end
  end

  initial begin : watchdog
    longint limit_ns;
    @(posedge i_arst_n);
    limit_ns = longint'(total_samples * CYCLES_PER_SAMPLE + NUM_ROWS * ROW_OVERHEAD)
               * longint'(CLK_PERIOD);
    #(limit_ns);
    report_failure("Timeout, the stream did not finish in the allowed time");
  end

  initial begin : main
    i_arst_n    = 1'b0;
    i_in_tdata  = '0;
    i_in_tlast  = 1'b0;
    i_in_tvalid = 1'b0;
    i_set_stb   = 1'b0;
    i_set_addr  = '0;
    i_set_data  = '0;
    i_rb_addr   = '0;
    model_coefs = '0;
    for (int j = 0; j < NUM_TAPS; j++) begin
      hist_i[3'(j)]    = '0;
      hist_q[3'(j)]    = '0;
      hist_bank[3'(j)] = '0;
    end
    fill_table();
    repeat (4) @(posedge ce_clk);
    @(negedge ce_clk);
    i_arst_n = 1'b1;
    @(negedge ce_clk);
    check_value("o_out_tvalid", 64'(o_out_tvalid), 64'd0);
    check_value("o_in_tready", 64'(o_in_tready), 64'd1);
    check_readback(8'd0, 64'd8);
    check_readback(8'd1, 64'h0BAD_C0DE_0BAD_C0DE);
    check_readback(SR_RELOAD, 64'h0BAD_C0DE_0BAD_C0DE);
    check_readback(8'hFF, 64'h0BAD_C0DE_0BAD_C0DE);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(rows[3'(r)]);
    end
    assert (exp_q.size() == 0) else report_failure("Some expected outputs never arrived");
    assert (clip_hits > 0) else report_failure("No output reached the saturation limits");
    assert (ready_low_hits > 0) else report_failure(
      "o_in_tready never dropped while the output was stalled");
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* logic/fir_block.sv */
/*
 * Streaming complex FIR filter with eight real Q1.15 taps,
 * round-and-clip output and settings-bus coefficient reload
 */
`timescale 1ns/100ps

module fir_block import fir_dsp_pkg::*; (
  input  logic        ce_clk,
  input  logic        i_arst_n,
  // Input sample stream
  input  logic [31:0] i_in_tdata,
  input  logic        i_in_tlast,
  input  logic        i_in_tvalid,
  output logic        o_in_tready,
  // Output sample stream
  output logic [31:0] o_out_tdata,
  output logic        o_out_tlast,
  output logic        o_out_tvalid,
  input  logic        i_out_tready,
  // Settings and readback
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic [7:0]  i_rb_addr,
  output logic [63:0] o_rb_data
);

  coef_bank_t coefs;

  // Entry k is the partial sum out of tap k
  acc_t       acc_chain [NUM_TAPS+1];

  fir_sample_bus_if sample_bus ();

  //////////////////////////////////////////////////////////////////////
  // Coefficients
  //////////////////////////////////////////////////////////////////////

  fir_coef_regs u_coef_regs (
    .ce_clk     (ce_clk),
    .i_arst_n   (i_arst_n),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_coefs    (coefs),
    .o_rb_data  (o_rb_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  fir_sample_feed u_feed (
    .ce_clk      (ce_clk),
    .i_arst_n    (i_arst_n),
    .i_in_tdata  (i_in_tdata),
    .i_in_tlast  (i_in_tlast),
    .i_in_tvalid (i_in_tvalid),
    .o_in_tready (o_in_tready),
    .bus         (sample_bus)
  );

  // Chain starts from zero at the far end
  assign acc_chain[NUM_TAPS] = '0;

  for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
    fir_tap u_tap (
      .ce_clk   (ce_clk),
      .i_arst_n (i_arst_n),
      .i_coef   (coefs[k]),
      .i_acc    (acc_chain[k+1]),
      .o_acc    (acc_chain[k]),
      .bus      (sample_bus)
    );
  end

  fir_round_clip u_round_clip (
    .ce_clk       (ce_clk),
    .i_arst_n     (i_arst_n),
    .i_acc        (acc_chain[0]),
    .i_out_tready (i_out_tready),
    .o_out_tdata  (o_out_tdata),
    .o_out_tlast  (o_out_tlast),
    .o_out_tvalid (o_out_tvalid),
    .bus          (sample_bus)
  );

endmodule

/* logic/fir_round_clip.sv */
/*
 * FIR output stage: round and saturate tap 0's sum back to
 * 16-bit I/Q, queue results and drive the output stream
 */
`timescale 1ns/100ps

module fir_round_clip import fir_dsp_pkg::*; (
  input  logic        ce_clk,
  input  logic        i_arst_n,
  input  acc_t        i_acc,
  input  logic        i_out_tready,
  output logic [31:0] o_out_tdata,
  output logic        o_out_tlast,
  output logic        o_out_tvalid,
  fir_sample_bus_if.drain bus
);

  typedef struct packed {
    logic    last;
    sample_t data;
  } out_entry_t;

  logic                               adv_d;
  logic                               last_d;
  out_entry_t                         entry;
  out_entry_t                         mem [OUT_DEPTH];
  logic [$clog2(OUT_DEPTH)-1:0]       wr_ptr;
  logic [$clog2(OUT_DEPTH)-1:0]       rd_ptr;
  logic [$clog2(OUT_DEPTH+1)-1:0]     count;
  logic                               push;
  logic                               pop;

  // Add half an LSB, drop ROUND_SHIFT bits, clamp to 16 bits
  function automatic logic signed [SAMPLE_W-1:0] round_sat(
    input logic signed [ACC_W-1:0] a
  );
    logic signed [ACC_W-1:0]             biased;
    logic signed [ACC_W-ROUND_SHIFT-1:0] shifted;
    biased  = a + (ACC_W'(1) << (ROUND_SHIFT - 1));
    shifted = biased[ACC_W-1:ROUND_SHIFT];
    if ((shifted[ACC_W-ROUND_SHIFT-1:SAMPLE_W-1] == '0) ||
        (shifted[ACC_W-ROUND_SHIFT-1:SAMPLE_W-1] == '1)) begin
      return shifted[SAMPLE_W-1:0];
    end else if (shifted[ACC_W-ROUND_SHIFT-1]) begin
      return {1'b1, {(SAMPLE_W-1){1'b0}}};
    end else begin
      return {1'b0, {(SAMPLE_W-1){1'b1}}};
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Result alignment
  //////////////////////////////////////////////////////////////////////

  // Tap 0 holds the new result one cycle after advance
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      adv_d  <= 1'b0;
      last_d <= 1'b0;
    end else begin
      adv_d  <= bus.advance;
      last_d <= bus.last;
    end
  end

  assign entry.last   = last_d;
  assign entry.data.i = round_sat(i_acc.i);
  assign entry.data.q = round_sat(i_acc.q);

  //////////////////////////////////////////////////////////////////////
  // Output queue
  //////////////////////////////////////////////////////////////////////

  assign push = adv_d;
  assign pop  = o_out_tvalid && i_out_tready;

  always_ff @(posedge ce_clk) begin
    if (push) begin
      mem[wr_ptr] <= entry;
    end
  end

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Leave space for the result still in the taps
  assign bus.room = (int'(count) + int'(adv_d)) < OUT_DEPTH;

  assign o_out_tvalid = (count != '0);
  assign o_out_tdata  = mem[rd_ptr].data;
  assign o_out_tlast  = mem[rd_ptr].last;

  // Room accounting upstream keeps a full queue from taking a push
  a_no_overflow: assert property (
    @(posedge ce_clk) disable iff (!i_arst_n)
    (count == OUT_DEPTH) |-> (!push || pop)
  );

endmodule

/* logic/fir_tap.sv */
/*
 * One transposed-form FIR tap: complex sample times a real
 * coefficient, added to the partial sum of the next tap
 */
`timescale 1ns/100ps

module fir_tap import fir_dsp_pkg::*; (
  input  logic  ce_clk,
  input  logic  i_arst_n,
  input  coef_t i_coef,
  input  acc_t  i_acc,
  output acc_t  o_acc,
  fir_sample_bus_if.tap bus
);

  // Full-precision products, Q1.15 times Q1.15
  logic signed [SAMPLE_W+COEF_W-1:0] prod_i;
  logic signed [SAMPLE_W+COEF_W-1:0] prod_q;

  acc_t acc_q;

  assign prod_i = bus.sample.i * i_coef;
  assign prod_q = bus.sample.q * i_coef;

  // One stage of filter history, moves only on accepted samples
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      acc_q <= '0;
    end else if (bus.advance) begin
      acc_q.i <= i_acc.i + prod_i;
      acc_q.q <= i_acc.q + prod_q;
    end
  end

  assign o_acc = acc_q;

endmodule

/* logic/fir_sample_feed.sv */
/*
 * FIR input stage: accepts the input stream and broadcasts
 * each accepted sample to the taps with an advance strobe
 */
`timescale 1ns/100ps

module fir_sample_feed import fir_dsp_pkg::*; (
  input  logic        ce_clk,
  input  logic        i_arst_n,
  input  logic [31:0] i_in_tdata,
  input  logic        i_in_tlast,
  input  logic        i_in_tvalid,
  output logic        o_in_tready,
  fir_sample_bus_if.feed bus
);

  logic accept;

  // Ready follows the drain's free space, so nothing is dropped
  assign o_in_tready = bus.room;

  // Transfer at the next edge
  assign accept = i_in_tvalid && bus.room;

  assign bus.advance = accept;
  assign bus.sample  = sample_t'(i_in_tdata);

  // Last only means something together with advance
  assign bus.last    = i_in_tlast && accept;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Tap registers only move while the drain has space for the result
  a_advance_has_room: assert property (
    @(posedge ce_clk) disable iff (!i_arst_n)
    bus.advance |-> bus.room
  );

endmodule

/* logic/fir_coef_regs.sv */
/*
 * FIR coefficient registers: staging shift bank, commit to the
 * active bank, and the tap-count readback
 */
`timescale 1ns/100ps

module fir_coef_regs import fir_dsp_pkg::*, fir_regs_pkg::*; (
  input  logic        ce_clk,
  input  logic        i_arst_n,
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic [7:0]  i_rb_addr,
  output coef_bank_t  o_coefs,
  output logic [63:0] o_rb_data
);

  coef_bank_t staging;
  coef_bank_t active;
  logic       staging_full;

  logic       reload_wr;
  logic       reload_last;
  logic       config_wr;

  //////////////////////////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////////////////////////

  assign reload_last = (i_set_addr == SR_RELOAD_LAST);
  assign reload_wr   = i_set_stb && ((i_set_addr == SR_RELOAD) || reload_last);
  assign config_wr   = i_set_stb && (i_set_addr == SR_CONFIG);

  // New coefficient enters at the top, older ones move toward tap 0
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      staging      <= '0;
      staging_full <= 1'b0;
    end else if (reload_wr) begin
      staging      <= {coef_t'(i_set_data[COEF_W-1:0]), staging[NUM_TAPS-1:1]};
      staging_full <= reload_last;
    end else if (config_wr) begin
      staging_full <= 1'b0;
    end
  end

  // Commit only a complete set
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      active <= '0;
    end else if (config_wr && staging_full) begin
      active <= staging;
    end
  end

  assign o_coefs = active;

  //////////////////////////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (i_rb_addr)
      RB_NUM_TAPS: o_rb_data = 64'(NUM_TAPS);
      default:     o_rb_data = RB_BAD_ADDR;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Taps see new coefficients only after a config write
  a_active_needs_config: assert property (
    @(posedge ce_clk) disable iff (!i_arst_n)
    !config_wr |=> $stable(active)
  );

endmodule

/* logic/fir_sample_bus_if.sv */
/*
 * Sample broadcast bus from the input feed to the tap array
 * and the drain, with the drain's room signal coming back
 */
`timescale 1ns/100ps

interface fir_sample_bus_if import fir_dsp_pkg::*; ();

  // Accepted input sample
  sample_t sample;

  // One-cycle strobe, high when the input transfer happens
  logic    advance;

  // Packet end, valid with advance
  logic    last;

  // Drain can take one more result
  logic    room;

  modport feed (
    output sample,
    output advance,
    output last,
    input  room
  );

  modport tap (
    input  sample,
    input  advance
  );

  modport drain (
    input  advance,
    input  last,
    output room
  );

endinterface

/* logic/fir_regs_pkg.sv */
/*
 * FIR settings bus map and readback constants
 */
package fir_regs_pkg;

  // Settings register base, matching the wrapper's user space
  localparam logic [7:0] SR_BASE = 8'd128;

  //////////////////////////////////////////////////////////////////////
  // Write addresses
  //////////////////////////////////////////////////////////////////////

  // Shift one coefficient into staging
  localparam logic [7:0] SR_RELOAD = SR_BASE + 8'd1;

  // Shift the final coefficient and mark staging complete
  localparam logic [7:0] SR_RELOAD_LAST = SR_BASE + 8'd2;

  // Commit staging to active
  localparam logic [7:0] SR_CONFIG = SR_BASE + 8'd3;

  //////////////////////////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////////////////////////

  localparam logic [7:0] RB_NUM_TAPS = 8'd0;

  // Returned for any address not decoded
  localparam logic [63:0] RB_BAD_ADDR = 64'h0BAD_C0DE_0BAD_C0DE;

endpackage

/* logic/fir_dsp_pkg.sv */
/*
 * FIR datapath definitions: tap count, component widths,
 * and the sample, coefficient and accumulator types
 */
package fir_dsp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Filter length
  localparam int NUM_TAPS = 8;

  // One I or Q component on the streams
  localparam int SAMPLE_W = 16;

  // Signed Q1.15 coefficient
  localparam int COEF_W = 16;

  // 32-bit product plus three guard bits for eight taps
  localparam int ACC_W = 35;

  // Bits dropped on the way back to sample scale
  localparam int ROUND_SHIFT = 15;

  // Output queue entries
  localparam int OUT_DEPTH = 4;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // I in the upper half, Q in the lower half
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
  } sample_t;

  typedef logic signed [COEF_W-1:0] coef_t;

  typedef struct packed {
    logic signed [ACC_W-1:0] i;
    logic signed [ACC_W-1:0] q;
  } acc_t;

  // Element k feeds tap k
  typedef coef_t [NUM_TAPS-1:0] coef_bank_t;

endpackage
